//--- Makefile
SIM_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module gat_tb -Mdir $(SIM_DIR)

run: compile
	./$(SIM_DIR)/Vgat_tb > $(LOG) 2>&1 || echo "Some tests failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
		echo "Simulation FAILED"; \
		exit 1; \
	fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(SIM_DIR) $(LOG)

//--- all.f
design/gat_pkg.sv
design/gat_bram.sv
design/stage_fifo.sv
design/coef_unit.sv
design/softmax_unit.sv
design/aggregator.sv
design/gat_top.sv
dv/gat_tb.sv

//--- design/aggregator.sv
`timescale 1ns/1ps

module aggregator (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          valid_i,
  input  gat_pkg::alpha_rec_t           alpha_i,
  output logic [gat_pkg::WH_ADDR_W-1:0] wh_addr_o,
  input  gat_pkg::wh_row_t              wh_dout_i,
  output logic                          aggr_pre_ready_o,
  output logic                          result_valid_o,
  output gat_pkg::result_t              result_o
);
  import gat_pkg::*;

  unit_state_e           state_q;
  alpha_rec_t            rec_q;
  logic [NODE_CNT_W-1:0] row_q;
  logic [NODE_CNT_W-1:0] lane;
  acc_t [FEAT_N-1:0]     acc_q;
  acc_t [FEAT_N-1:0]     acc_nxt;
  result_t               res_q;
  logic                  valid_q;
  logic [SG_ADDR_W-1:0]  sg_idx_q;

  assign wh_addr_o = rec_q.start_row + WH_ADDR_W'(row_q);
  assign lane      = row_q - 1'b1;

  // One multiply-accumulate per feature on the row that just arrived
  always_comb begin
    for (int f = 0; f < FEAT_N; f++) begin
      acc_nxt[f] = acc_q[f] + $signed({1'b0, rec_q.alpha[lane[LANE_W-1:0]]}) * wh_dout_i.feat[f];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= IDLE;
      row_q    <= '0;
      valid_q  <= 1'b0;
      sg_idx_q <= '0;
    end else begin
      valid_q <= (state_q == DONE);
      case (state_q)
        IDLE: begin
          if (valid_i) begin
            row_q   <= '0;
            state_q <= CALC;
          end
        end
        CALC: begin
          row_q <= row_q + 1'b1;
          if (row_q == rec_q.node_cnt - 1'b1) begin
            state_q <= DONE;
          end
        end
        DONE: begin
          // Wraps across graphs
          sg_idx_q <= sg_idx_q + 1'b1;
          state_q  <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && valid_i) begin
      rec_q <= alpha_i;
      acc_q <= '0;
    end
    if (state_q == CALC && row_q != '0) begin
      acc_q <= acc_nxt;
    end
    if (state_q == DONE) begin
      for (int f = 0; f < FEAT_N; f++) begin
        res_q.sum[f] <= acc_nxt[f] >>> ALPHA_FRAC;
      end
      res_q.sg_idx <= sg_idx_q;
    end
  end

  assign result_valid_o   = valid_q;
  assign aggr_pre_ready_o = valid_q;
  assign result_o         = res_q;

endmodule

//--- design/coef_unit.sv
`timescale 1ns/1ps

module coef_unit (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start_i,
  input  logic [gat_pkg::SG_CNT_W-1:0]  sg_count_i,
  input  gat_pkg::wh_row_t              a_i,
  output logic [gat_pkg::SG_ADDR_W-1:0] sg_addr_o,
  input  gat_pkg::sg_info_t             sg_dout_i,
  output logic [gat_pkg::WH_ADDR_W-1:0] wh_addr_o,
  input  gat_pkg::wh_row_t              wh_dout_i,
  input  logic                          fifo_full_i,
  output logic                          coef_done_o,
  output gat_pkg::coef_rec_t            coef_o
);
  import gat_pkg::*;

  unit_state_e           state_q;
  logic [SG_ADDR_W-1:0]  sg_idx_q;
  logic [SG_CNT_W-1:0]   sg_num_q;
  logic [NODE_CNT_W-1:0] row_q;
  logic [NODE_CNT_W-1:0] lane;
  logic                  stall;
  data_t                 coef_sat;
  coef_rec_t             rec_q;
  logic                  done_q;

  function automatic data_t dot_sat(wh_row_t a, wh_row_t row);
    logic signed [2*DATA_W-1:0] prod;
    logic signed [2*DATA_W:0]   sum;
    sum = '0;
    for (int f = 0; f < FEAT_N; f++) begin
      prod = $signed(a.feat[f]) * $signed(row.feat[f]);
      sum  = sum + prod;
    end
    if (sum > DATA_MAX) begin
      return data_t'(DATA_MAX);
    end else if (sum < DATA_MIN) begin
      return data_t'(DATA_MIN);
    end
    return data_t'(sum);
  endfunction

  // Table entry is valid from the first CALC cycle on
  assign sg_addr_o = sg_idx_q;
  assign wh_addr_o = sg_dout_i.start_row + WH_ADDR_W'(row_q);

  // Row data lags the address by one cycle
  assign lane     = row_q - 1'b1;
  assign coef_sat = dot_sat(a_i, wh_dout_i);

  // Hold the first row while the softmax FIFO has no room
  assign stall = (state_q == CALC) && (row_q == '0) && fifo_full_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= IDLE;
      sg_idx_q <= '0;
      sg_num_q <= '0;
      row_q    <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= (state_q == DONE);
      case (state_q)
        IDLE: begin
          if (start_i && sg_count_i != '0) begin
            sg_idx_q <= '0;
            sg_num_q <= sg_count_i;
            state_q  <= FETCH;
          end
        end
        FETCH: begin
          row_q   <= '0;
          state_q <= CALC;
        end
        CALC: begin
          if (!stall) begin
            row_q <= row_q + 1'b1;
            if (row_q == sg_dout_i.node_cnt - 1'b1) begin
              state_q <= DONE;
            end
          end
        end
        DONE: begin
          sg_idx_q <= sg_idx_q + 1'b1;
          if ({1'b0, sg_idx_q} == sg_num_q - 1'b1) begin
            state_q <= IDLE;
          end else begin
            state_q <= FETCH;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == FETCH) begin
      rec_q.coef <= '0;
    end
    if ((state_q == CALC && row_q != '0) || state_q == DONE) begin
      rec_q.coef[lane[LANE_W-1:0]] <= coef_sat;
    end
    if (state_q == DONE) begin
      rec_q.node_cnt  <= sg_dout_i.node_cnt;
      rec_q.start_row <= sg_dout_i.start_row;
    end
  end

  assign coef_done_o = done_q;
  assign coef_o      = rec_q;

  a_node_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
    state_q == CALC |-> sg_dout_i.node_cnt inside {[1:MAX_NODES]});

endmodule

//--- design/gat_bram.sv
`timescale 1ns/1ps

module gat_bram #(
  parameter type DATA_T = logic [7:0],
  parameter int  DEPTH  = 32
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  DATA_T                    din_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output DATA_T                    dout_o
);

  DATA_T mem [DEPTH];

  // Port A writes, port B reads with one cycle of latency
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= din_i;
    end
    dout_o <= mem[raddr_i];
  end

endmodule

//--- design/gat_pkg.sv
package gat_pkg;

  localparam int DATA_W     = 8;
  localparam int FEAT_N     = 2;
  localparam int MAX_NODES  = 4;
  localparam int LANE_W     = $clog2(MAX_NODES);
  localparam int WH_DEPTH   = 32;
  localparam int WH_ADDR_W  = 5;
  localparam int SG_DEPTH   = 8;
  localparam int SG_ADDR_W  = 3;
  localparam int SG_CNT_W   = SG_ADDR_W + 1;
  localparam int NODE_CNT_W = 3;
  localparam int ALPHA_W    = 8;
  localparam int ALPHA_FRAC = 7;
  localparam int ACC_W      = 20;
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = 2;
  localparam int FIFO_CNT_W = 3;

  // Saturation bounds of a coefficient
  localparam int DATA_MAX = 2**(DATA_W-1) - 1;
  localparam int DATA_MIN = -(2**(DATA_W-1));

  // Weight of 1.0
  localparam logic [ALPHA_W-1:0] ALPHA_ONE = ALPHA_W'(1 << ALPHA_FRAC);

  typedef logic signed [DATA_W-1:0] data_t;
  typedef logic        [ALPHA_W-1:0] alpha_t;
  typedef logic signed [ACC_W-1:0]   acc_t;

  typedef struct packed {
    data_t [FEAT_N-1:0] feat;
  } wh_row_t;

  typedef struct packed {
    logic [WH_ADDR_W-1:0]  start_row;
    logic [NODE_CNT_W-1:0] node_cnt;
  } sg_info_t;

  typedef struct packed {
    data_t [MAX_NODES-1:0] coef;
    logic [NODE_CNT_W-1:0] node_cnt;
    logic [WH_ADDR_W-1:0]  start_row;
  } coef_rec_t;

  typedef struct packed {
    alpha_t [MAX_NODES-1:0] alpha;
    logic [NODE_CNT_W-1:0]  node_cnt;
    logic [WH_ADDR_W-1:0]   start_row;
  } alpha_rec_t;

  typedef struct packed {
    acc_t [FEAT_N-1:0]    sum;
    logic [SG_ADDR_W-1:0] sg_idx;
  } result_t;

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    CALC,
    DONE
  } unit_state_e;

endpackage

//--- design/gat_top.sv
`timescale 1ns/1ps

module gat_top (
  input  logic                          clk,
  input  logic                          rst_n,

  input  logic                          wh_we_i,
  input  logic [gat_pkg::WH_ADDR_W-1:0] wh_addr_i,
  input  gat_pkg::wh_row_t              wh_din_i,
  input  logic                          wh_load_done_i,

  input  logic                          a_we_i,
  input  gat_pkg::wh_row_t              a_din_i,
  input  logic                          a_load_done_i,

  input  logic                          sg_we_i,
  input  logic [gat_pkg::SG_ADDR_W-1:0] sg_addr_i,
  input  gat_pkg::sg_info_t             sg_din_i,
  input  logic                          sg_load_done_i,

  input  logic [gat_pkg::SG_CNT_W-1:0]  sg_count_i,
  output logic                          busy_o,
  output logic                          result_valid_o,
  output gat_pkg::result_t              result_o
);
  import gat_pkg::*;

  wh_row_t               a_q;
  logic                  load_all;
  logic                  load_all_q;
  logic                  start;
  logic [SG_CNT_W-1:0]   pending_q;

  logic [SG_ADDR_W-1:0]  sg_rd_addr;
  sg_info_t              sg_rd_data;
  logic [WH_ADDR_W-1:0]  wh1_rd_addr;
  wh_row_t               wh1_rd_data;
  logic [WH_ADDR_W-1:0]  wh2_rd_addr;
  wh_row_t               wh2_rd_data;

  coef_rec_t             coef_rec;
  coef_rec_t             sm_fifo_dout;
  coef_rec_t             sm_rec_q;
  alpha_rec_t            alpha_rec;
  alpha_rec_t            aggr_fifo_dout;
  alpha_rec_t            aggr_rec_q;
  logic                  coef_done;
  logic                  sm_done;
  logic                  sm_fifo_full;

  // Bit 0 is the softmax stage, bit 1 the aggregation stage
  logic [1:0]            fifo_empty;
  logic [1:0]            pre_ready;
  logic [1:0]            pop;
  logic [1:0]            first_q;
  logic [1:0]            valid_q;

  always_ff @(posedge clk) begin
    if (a_we_i) begin
      a_q <= a_din_i;
    end
  end

  // Start on the rising edge of all three load levels
  assign load_all = wh_load_done_i && a_load_done_i && sg_load_done_i;
  assign start    = load_all && !load_all_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_all_q <= 1'b0;
      pending_q  <= '0;
    end else begin
      load_all_q <= load_all;
      if (start) begin
        pending_q <= sg_count_i;
      end else if (result_valid_o && pending_q != '0) begin
        pending_q <= pending_q - 1'b1;
      end
    end
  end

  assign busy_o = (pending_q != '0);

  // Two copies of WH give the two stages their own read port
  gat_bram #(.DATA_T(wh_row_t), .DEPTH(WH_DEPTH)) u_wh1_bram (
    .clk     (clk),
    .we_i    (wh_we_i),
    .waddr_i (wh_addr_i),
    .din_i   (wh_din_i),
    .raddr_i (wh1_rd_addr),
    .dout_o  (wh1_rd_data)
  );

  gat_bram #(.DATA_T(wh_row_t), .DEPTH(WH_DEPTH)) u_wh2_bram (
    .clk     (clk),
    .we_i    (wh_we_i),
    .waddr_i (wh_addr_i),
    .din_i   (wh_din_i),
    .raddr_i (wh2_rd_addr),
    .dout_o  (wh2_rd_data)
  );

  gat_bram #(.DATA_T(sg_info_t), .DEPTH(SG_DEPTH)) u_sg_bram (
    .clk     (clk),
    .we_i    (sg_we_i),
    .waddr_i (sg_addr_i),
    .din_i   (sg_din_i),
    .raddr_i (sg_rd_addr),
    .dout_o  (sg_rd_data)
  );

  coef_unit u_coef_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start),
    .sg_count_i  (sg_count_i),
    .a_i         (a_q),
    .sg_addr_o   (sg_rd_addr),
    .sg_dout_i   (sg_rd_data),
    .wh_addr_o   (wh1_rd_addr),
    .wh_dout_i   (wh1_rd_data),
    .fifo_full_i (sm_fifo_full),
    .coef_done_o (coef_done),
    .coef_o      (coef_rec)
  );

  stage_fifo #(.REC_T(coef_rec_t)) u_sm_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (coef_done),
    .din_i   (coef_rec),
    .rd_i    (pop[0]),
    .dout_o  (sm_fifo_dout),
    .empty_o (fifo_empty[0]),
    .full_o  (sm_fifo_full)
  );

  // Pop on the first item, or when the stage asks for the next one
  assign pop = ~fifo_empty & ((first_q & ~valid_q) | pre_ready);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_q <= 2'b11;
      valid_q <= 2'b00;
    end else begin
      valid_q <= pop;
      for (int s = 0; s < 2; s++) begin
        if (valid_q[s]) begin
          first_q[s] <= 1'b0;
        end else if (pre_ready[s] && fifo_empty[s]) begin
          // Stage drained its FIFO, the next record pops on arrival
          first_q[s] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop[0]) begin
      sm_rec_q <= sm_fifo_dout;
    end
    if (pop[1]) begin
      aggr_rec_q <= aggr_fifo_dout;
    end
  end

  softmax_unit u_softmax_unit (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_q[0]),
    .coef_i         (sm_rec_q),
    .sm_done_o      (sm_done),
    .sm_pre_ready_o (pre_ready[0]),
    .alpha_o        (alpha_rec)
  );

  // Softmax needs three cycles per record, so this one cannot fill up
  stage_fifo #(.REC_T(alpha_rec_t)) u_aggr_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (sm_done),
    .din_i   (alpha_rec),
    .rd_i    (pop[1]),
    .dout_o  (aggr_fifo_dout),
    .empty_o (fifo_empty[1]),
    .full_o  ()
  );

  aggregator u_aggregator (
    .clk              (clk),
    .rst_n            (rst_n),
    .valid_i          (valid_q[1]),
    .alpha_i          (aggr_rec_q),
    .wh_addr_o        (wh2_rd_addr),
    .wh_dout_i        (wh2_rd_data),
    .aggr_pre_ready_o (pre_ready[1]),
    .result_valid_o   (result_valid_o),
    .result_o         (result_o)
  );

  a_result_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid_o |-> busy_o);

endmodule

//--- design/softmax_unit.sv
`timescale 1ns/1ps

module softmax_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                valid_i,
  input  gat_pkg::coef_rec_t  coef_i,
  output logic                sm_done_o,
  output logic                sm_pre_ready_o,
  output gat_pkg::alpha_rec_t alpha_o
);
  import gat_pkg::*;

  unit_state_e             state_q;
  coef_rec_t               rec_q;
  data_t                   max_c;
  data_t                   max_q;
  alpha_t [MAX_NODES-1:0]  weight;
  alpha_rec_t              alpha_q;

  // Largest coefficient among the used lanes, lane 0 is always used
  always_comb begin
    max_c = coef_i.coef[0];
    for (int j = 1; j < MAX_NODES; j++) begin
      if (j < coef_i.node_cnt && coef_i.coef[j] > max_c) begin
        max_c = coef_i.coef[j];
      end
    end
  end

  // Power of two weight from the distance to the maximum
  always_comb begin
    logic signed [DATA_W:0] diff;
    for (int j = 0; j < MAX_NODES; j++) begin
      diff = max_q - rec_q.coef[j];
      if (j >= rec_q.node_cnt) begin
        weight[j] = '0;
      end else if (diff >= ALPHA_FRAC) begin
        weight[j] = ALPHA_ONE >> ALPHA_FRAC;
      end else begin
        weight[j] = ALPHA_ONE >> diff;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (valid_i) begin
            state_q <= CALC;
          end
        end
        CALC:    state_q <= DONE;
        DONE:    state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && valid_i) begin
      rec_q <= coef_i;
      max_q <= max_c;
    end
    if (state_q == CALC) begin
      alpha_q.alpha     <= weight;
      alpha_q.node_cnt  <= rec_q.node_cnt;
      alpha_q.start_row <= rec_q.start_row;
    end
  end

  // Done writes the next FIFO and asks for the next record in the same cycle
  assign sm_done_o      = (state_q == DONE);
  assign sm_pre_ready_o = (state_q == DONE);
  assign alpha_o        = alpha_q;

  a_valid_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    valid_i |-> state_q == IDLE);

endmodule

//--- design/stage_fifo.sv
`timescale 1ns/1ps

module stage_fifo #(
  parameter type REC_T = logic [7:0]
) (
  input  logic clk,
  input  logic rst_n,
  input  logic wr_i,
  input  REC_T din_i,
  input  logic rd_i,
  output REC_T dout_o,
  output logic empty_o,
  output logic full_o
);
  import gat_pkg::*;

  REC_T                  mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] cnt_q;
  logic                  do_wr;
  logic                  do_rd;

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == FIFO_CNT_W'(FIFO_DEPTH));
  assign do_wr   = wr_i && !full_o;
  assign do_rd   = rd_i && !empty_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_rd) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_wr && !do_rd) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_rd && !do_wr) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr_q] <= din_i;
    end
  end

  // Head of queue, read without a register
  assign dout_o = mem[rd_ptr_q];

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(wr_i && full_o));
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !(rd_i && empty_o));

endmodule

//--- dv/gat_tb.sv
`timescale 1ns/1ps

module gat_tb;
  import gat_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int HOLD_CYCLES  = 12;
  localparam int N_GRAPHS     = 11;
  localparam int LOAD_CYCLES  = WH_DEPTH + SG_DEPTH + 4;
  localparam int CALC_CYCLES  = SG_DEPTH * (MAX_NODES + 2) + 16;
  localparam int GRAPH_CYCLES = LOAD_CYCLES + HOLD_CYCLES + CALC_CYCLES;
  localparam int WATCHDOG_NS  = 20 * GRAPH_CYCLES * N_GRAPHS * CLK_PERIOD;

  logic                 clk;
  logic                 rst_n;
  logic                 wh_we;
  logic [WH_ADDR_W-1:0] wh_addr;
  wh_row_t              wh_din;
  logic                 wh_load_done;
  logic                 a_we;
  wh_row_t              a_din;
  logic                 a_load_done;
  logic                 sg_we;
  logic [SG_ADDR_W-1:0] sg_addr;
  sg_info_t             sg_din;
  logic                 sg_load_done;
  logic [SG_CNT_W-1:0]  sg_count;
  logic                 busy;
  logic                 result_valid;
  result_t              result;

  // Graph image kept on the testbench side
  int          wh_f [WH_DEPTH][FEAT_N];
  int          a_f [FEAT_N];
  int          sg_start [SG_DEPTH];
  int          sg_cnt [SG_DEPTH];
  int          sg_num;

  int          exp_sum_q [$];
  int          exp_idx_q [$];
  int          next_idx;
  int          exp_idx;
  int          exp_val;
  int          got_val;
  string       test_name;
  logic [31:0] rng_state;
  int          errors;
  int          checks;

  gat_top dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .wh_we_i        (wh_we),
    .wh_addr_i      (wh_addr),
    .wh_din_i       (wh_din),
    .wh_load_done_i (wh_load_done),
    .a_we_i         (a_we),
    .a_din_i        (a_din),
    .a_load_done_i  (a_load_done),
    .sg_we_i        (sg_we),
    .sg_addr_i      (sg_addr),
    .sg_din_i       (sg_din),
    .sg_load_done_i (sg_load_done),
    .sg_count_i     (sg_count),
    .busy_o         (busy),
    .result_valid_o (result_valid),
    .result_o       (result)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int rand_range(int lo, int hi);
    int r;
    r = int'(lcg_next() >> 8) % (hi - lo + 1);
    return lo + r;
  endfunction

  function automatic int clamp_coef(int v);
    if (v > DATA_MAX) begin
      return DATA_MAX;
    end
    if (v < DATA_MIN) begin
      return DATA_MIN;
    end
    return v;
  endfunction

  // Expected feature sum f of subgraph k
  function automatic int expected_sum(int k, int f);
    int coef [MAX_NODES];
    int m;
    int sh;
    int row;
    int dot;
    int acc;
    acc = 0;
    for (int j = 0; j < sg_cnt[k]; j++) begin
      row = (sg_start[k] + j) % WH_DEPTH;
      dot = 0;
      for (int g = 0; g < FEAT_N; g++) begin
        dot += a_f[g] * wh_f[row][g];
      end
      coef[j] = clamp_coef(dot);
    end
    m = coef[0];
    for (int j = 1; j < sg_cnt[k]; j++) begin
      if (coef[j] > m) begin
        m = coef[j];
      end
    end
    for (int j = 0; j < sg_cnt[k]; j++) begin
      sh = m - coef[j];
      if (sh > 7) begin
        sh = 7;
      end
      row = (sg_start[k] + j) % WH_DEPTH;
      acc += (128 >> sh) * wh_f[row][f];
    end
    return acc >>> 7;
  endfunction

  // Predicted results of the loaded graph in output order
  function automatic void queue_expected();
    for (int k = 0; k < sg_num; k++) begin
      for (int f = 0; f < FEAT_N; f++) begin
        exp_sum_q.push_back(expected_sum(k, f));
      end
      exp_idx_q.push_back(next_idx % SG_DEPTH);
      next_idx++;
    end
  endfunction

  task automatic make_graph(input int n_sg, input int cnt_lo, input int cnt_hi,
                            input int f_lo, input int f_hi, input int a_lo, input int a_hi);
    sg_num = n_sg;
    for (int r = 0; r < WH_DEPTH; r++) begin
      for (int g = 0; g < FEAT_N; g++) begin
        wh_f[r][g] = rand_range(f_lo, f_hi);
      end
    end
    for (int g = 0; g < FEAT_N; g++) begin
      a_f[g] = rand_range(a_lo, a_hi);
    end
    for (int k = 0; k < SG_DEPTH; k++) begin
      sg_start[k] = rand_range(0, WH_DEPTH - 1);
      sg_cnt[k]   = rand_range(cnt_lo, cnt_hi);
    end
  endtask

  task automatic load_graph();
    for (int r = 0; r < WH_DEPTH; r++) begin
      @(negedge clk);
      wh_we   = 1'b1;
      wh_addr = WH_ADDR_W'(r);
      for (int g = 0; g < FEAT_N; g++) begin
        wh_din.feat[g] = data_t'(wh_f[r][g]);
      end
    end
    @(negedge clk);
    wh_we = 1'b0;
    a_we  = 1'b1;
    for (int g = 0; g < FEAT_N; g++) begin
      a_din.feat[g] = data_t'(a_f[g]);
    end
    for (int k = 0; k < SG_DEPTH; k++) begin
      @(negedge clk);
      a_we             = 1'b0;
      sg_we            = 1'b1;
      sg_addr          = SG_ADDR_W'(k);
      sg_din.start_row = WH_ADDR_W'(sg_start[k]);
      sg_din.node_cnt  = NODE_CNT_W'(sg_cnt[k]);
    end
    @(negedge clk);
    sg_we    = 1'b0;
    sg_count = SG_CNT_W'(sg_num);
  endtask

  // held is the load_done level kept low for a while
  // With held at 3 all levels rise together
  task automatic run_graph(input string name, input int held);
    test_name = name;
    queue_expected();
    @(negedge clk);
    wh_load_done = (held != 0);
    a_load_done  = (held != 1);
    sg_load_done = (held != 2);
    if (held < 3) begin
      repeat (HOLD_CYCLES) begin
        @(negedge clk);
        checks++;
        if (busy || result_valid) begin
          $display("%s: engine started while load_done level %0d was low", name, held);
          errors++;
        end
      end
      wh_load_done = 1'b1;
      a_load_done  = 1'b1;
      sg_load_done = 1'b1;
    end
    @(negedge clk);
    checks++;
    if (!busy) begin
      $display("%s: busy_o did not rise after start", name);
      errors++;
    end
    while (exp_idx_q.size() != 0) begin
      @(posedge clk);
    end
    @(negedge clk);
    checks++;
    if (busy) begin
      $display("%s: busy_o still high after the last result", name);
      errors++;
    end
    wh_load_done = 1'b0;
    a_load_done  = 1'b0;
    sg_load_done = 1'b0;
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    repeat (5) @(negedge clk);
    rst_n    = 1'b1;
    next_idx = 0;
  endtask

  // Reset lands while subgraphs are still in flight
  task automatic reset_mid_run(input string name);
    test_name = name;
    queue_expected();
    @(negedge clk);
    wh_load_done = 1'b1;
    a_load_done  = 1'b1;
    sg_load_done = 1'b1;
    repeat (HOLD_CYCLES) @(negedge clk);
    checks++;
    if (busy !== 1'b1) begin
      $display("%s: busy_o was low with subgraphs still in flight", name);
      errors++;
    end
    wh_load_done = 1'b0;
    a_load_done  = 1'b0;
    sg_load_done = 1'b0;
    apply_reset();
    exp_sum_q.delete();
    exp_idx_q.delete();
  endtask

  task automatic check_idle(input string name);
    @(negedge clk);
    checks++;
    if (busy !== 1'b0 || result_valid !== 1'b0) begin
      $display("%s: busy_o or result_valid_o high after reset", name);
      errors++;
    end
  endtask

  // Results in order against the predicted queue
  always @(negedge clk) begin
    if (rst_n && result_valid) begin
      if (exp_idx_q.size() == 0) begin
        $display("%s: result_valid_o pulsed with no result outstanding", test_name);
        errors++;
      end else begin
        exp_idx = exp_idx_q.pop_front();
        checks++;
        if (int'(result.sg_idx) != exp_idx) begin
          $display("ERR %s sg_idx exp %0d got %0d", test_name, exp_idx, result.sg_idx);
          errors++;
        end
        for (int f = 0; f < FEAT_N; f++) begin
          exp_val = exp_sum_q.pop_front();
          got_val = $signed(result.sum[f]);
          checks++;
          if (got_val != exp_val) begin
            $display("ERR %s sg %0d sum[%0d] exp %0d got %0d",
                     test_name, exp_idx, f, exp_val, got_val);
            errors++;
          end
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with results still outstanding", WATCHDOG_NS);
    $display("checks %0d, errors %0d", checks, errors + 1);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    rng_state    = 32'heefb_fc94;
    errors       = 0;
    checks       = 0;
    next_idx     = 0;
    test_name    = "init";
    rst_n        = 1'b0;
    wh_we        = 1'b0;
    wh_addr      = '0;
    wh_din       = '0;
    wh_load_done = 1'b0;
    a_we         = 1'b0;
    a_din        = '0;
    a_load_done  = 1'b0;
    sg_we        = 1'b0;
    sg_addr      = '0;
    sg_din       = '0;
    sg_load_done = 1'b0;
    sg_count     = '0;

    apply_reset();
    check_idle("reset");

    // One neighbor gets the full weight
    make_graph(1, 1, 1, -128, 127, -128, 127);
    load_graph();
    run_graph("single", 3);

    repeat (2) begin
      make_graph(SG_DEPTH, 1, MAX_NODES, -20, 20, -6, 6);
      load_graph();
      run_graph("random", 3);
    end

    make_graph(SG_DEPTH, 1, MAX_NODES, -128, 127, 90, 127);
    load_graph();
    run_graph("saturate", 3);

    // Coefficient equals feature 0, so the spread is wide
    make_graph(SG_DEPTH, 2, MAX_NODES, -128, 127, 1, 1);
    a_f[1] = 0;
    load_graph();
    run_graph("spread", 3);

    for (int h = 0; h < 3; h++) begin
      make_graph(SG_DEPTH, 1, MAX_NODES, -40, 40, -3, 3);
      load_graph();
      run_graph("load_gate", h);
    end

    make_graph(SG_DEPTH, 1, MAX_NODES, -60, 60, -4, 4);
    load_graph();
    reset_mid_run("reset_mid_run");
    check_idle("reset_mid_run");
    repeat (2) begin
      make_graph(SG_DEPTH, 1, MAX_NODES, -60, 60, -4, 4);
      load_graph();
      run_graph("after_reset", 3);
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
